//--- logic/nodeBusPkg.sv
`default_nettype none

package nodeBusPkg;

	// core data channel
	localparam int DataWidth = 64;
	localparam int TagWidth = 8;
	localparam int SizeWidth = 3;

	// error and interrupt reporting
	localparam int SelWidth = 24;
	localparam int ErrCodeWidth = 29;
	localparam int IntCodeWidth = 16;

	// one word handed back to the core, 75 bits
	typedef struct packed {
		logic [SizeWidth-1:0] size;
		logic [TagWidth-1:0] tag;
		logic [DataWidth-1:0] data;
	} returnWord;

	// one logged error, 53 bits
	typedef struct packed {
		logic [SelWidth-1:0] sel;
		logic [ErrCodeWidth-1:0] code;
	} errorRecord;

endpackage

`default_nettype wire

//--- logic/nodeTimingPkg.sv
`default_nettype none

package nodeTimingPkg;

	// periodic tick, in clock cycles
	localparam int TickScale = 20;
	localparam int TickCountWidth = 8;

	// buffering
	localparam int ReturnFifoDepth = 16;
	localparam int ErrorFifoDepth = 8;

endpackage

`default_nettype wire

//--- logic/returnSource.sv
`timescale 1ns/1ps
`default_nettype none

interface returnSource;
	import nodeBusPkg::*;

	logic valid;
	logic pop;
	logic [SizeWidth-1:0] size;
	logic [TagWidth-1:0] tag;
	logic [DataWidth-1:0] data;

	// driven by a fifo head or the local port
	modport source (output valid, size, tag, data, input pop);

	// the merger consumes one word per pop pulse
	modport sink (input valid, size, tag, data, output pop);

endinterface

`default_nettype wire

//--- logic/syncFifo.sv
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
	parameter type T = logic [7:0],
	parameter int Depth = 16
)
(
	input wire EXTCLK,
	input wire rstN,
	input wire clear,
	input wire push,
	input wire T din,
	input wire pop,
	output T dout,
	output logic valid,
	output logic full
);

	T mem [Depth];
	logic [$clog2(Depth)-1:0] wrPtr;
	logic [$clog2(Depth)-1:0] rdPtr;
	logic [$clog2(Depth+1)-1:0] count;
	logic doPop;

	assign valid = (count != '0);
	assign full = (int'(count) == Depth);
	assign dout = mem[rdPtr];

	// empty pop does nothing
	assign doPop = pop & valid;

	always_ff @(posedge EXTCLK)
	begin
		if (push)
			mem[wrPtr] <= din;
	end

	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (int'(wrPtr) == Depth - 1) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (int'(rdPtr) == Depth - 1) ? '0 : rdPtr + 1'b1;
			// simultaneous push and pop keeps the count
			if (push != doPop)
				count <= push ? count + 1'b1 : count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/returnMerge.sv
`timescale 1ns/1ps
`default_nettype none

module returnMerge
(
	input wire EXTCLK,
	input wire rstN,
	returnSource.sink net,
	returnSource.sink stream,
	returnSource.sink localIn,
	output logic coreDrdy,
	output nodeBusPkg::returnWord coreWord
);
	import nodeBusPkg::*;

	logic takeNet;
	logic takeStream;
	logic takeLocal;
	logic anyTake;
	returnWord winner;

	// network first, then stream, local memory last
	assign takeNet = net.valid;
	assign takeStream = stream.valid & ~net.valid;
	assign takeLocal = localIn.valid & ~net.valid & ~stream.valid;
	assign anyTake = takeNet | takeStream | takeLocal;

	// the winner is consumed in the same cycle
	assign net.pop = takeNet;
	assign stream.pop = takeStream;
	assign localIn.pop = takeLocal;

	always_comb
	begin
		if (takeNet)
			winner = '{size: net.size, tag: net.tag, data: net.data};
		else if (takeStream)
			winner = '{size: stream.size, tag: stream.tag, data: stream.data};
		else
			winner = '{size: localIn.size, tag: localIn.tag, data: localIn.data};
	end

	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
			coreDrdy <= 1'b0;
		else
			coreDrdy <= anyTake;
	end

	// word only matters while coreDrdy is high
	always_ff @(posedge EXTCLK)
	begin
		if (anyTake)
			coreWord <= winner;
	end

endmodule

`default_nettype wire

//--- logic/tickTimer.sv
`timescale 1ns/1ps
`default_nettype none

module tickTimer
(
	input wire EXTCLK,
	input wire rstN,
	input wire clear,
	output logic tick
);
	import nodeTimingPkg::*;

	logic [TickCountWidth-1:0] count;

	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (clear)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		// last cycle of the period
		else if (count == TickCountWidth'(TickScale - 1))
		begin
			count <= '0;
			tick <= 1'b1;
		end
		else
		begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/nodeControl.sv
`timescale 1ns/1ps
`default_nettype none

module nodeControl
(
	input wire EXTCLK,
	input wire rstN,
	input wire softReset,
	input wire intReq,
	input wire [nodeBusPkg::IntCodeWidth-1:0] intCode,
	input wire intEna,
	input wire coreEmpty,
	input wire coreBkpt,
	input wire errValid,
	input wire errMsgAck,
	output logic nodeClear,
	output logic intAck,
	output logic [nodeBusPkg::IntCodeWidth-1:0] intVector,
	output logic coreStop,
	output logic errMsgReq
);

	typedef enum logic [1:0]
	{
		ErrIdle,
		ErrReq,
		ErrDone
	} errStateType;

	logic intPending;
	logic intGrant;
	errStateType errState;

	//==========================================================
	// soft reset filter
	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
			nodeClear <= 1'b0;
		else
			nodeClear <= softReset;
	end

	//==========================================================
	// interrupt sequencing

	// core drained and not parked on a breakpoint
	assign intGrant = intPending & intReq & intEna & coreEmpty & ~coreBkpt;
	assign coreStop = intPending;

	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			intPending <= 1'b0;
			intAck <= 1'b0;
		end
		else
		begin
			// held until granted, dropped when intEna goes away
			intPending <= (intPending | intReq) & intEna & ~intAck & ~intGrant;
			if (intGrant)
				intAck <= 1'b1;
			else if (!intReq)
				intAck <= 1'b0;
		end
	end

	always_ff @(posedge EXTCLK)
	begin
		if (intGrant)
			intVector <= intCode;
	end

	//==========================================================
	// error announcement handshake
	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
			errState <= ErrIdle;
		else
		begin
			case (errState)
				ErrIdle:
					if (errValid)
						errState <= ErrReq;
				ErrReq:
					if (errMsgAck)
						errState <= ErrDone;
				default:
					// wait for the host to release ack
					if (!errMsgAck)
						errState <= ErrIdle;
			endcase
		end
	end

	assign errMsgReq = (errState == ErrReq);

endmodule

`default_nettype wire

//--- logic/nodeHub.sv
`timescale 1ns/1ps
`default_nettype none

module nodeHub
(
	input wire EXTCLK,
	input wire rstN,
	input wire softReset,
	output logic tick,
	// stream controller returns
	input wire streamPush,
	input wire [nodeBusPkg::SizeWidth-1:0] streamSize,
	input wire [nodeBusPkg::TagWidth-1:0] streamTag,
	input wire [nodeBusPkg::DataWidth-1:0] streamData,
	output logic streamFull,
	// network returns
	input wire netPush,
	input wire [nodeBusPkg::SizeWidth-1:0] netSize,
	input wire [nodeBusPkg::TagWidth-1:0] netTag,
	input wire [nodeBusPkg::DataWidth-1:0] netData,
	output logic netFull,
	// local memory returns
	input wire localValid,
	input wire [nodeBusPkg::SizeWidth-1:0] localSize,
	input wire [nodeBusPkg::TagWidth-1:0] localTag,
	input wire [nodeBusPkg::DataWidth-1:0] localData,
	output logic localRd,
	// core data channel
	output logic coreDrdy,
	output logic [nodeBusPkg::SizeWidth-1:0] coreSize,
	output logic [nodeBusPkg::TagWidth-1:0] coreTag,
	output logic [nodeBusPkg::DataWidth-1:0] coreData,
	// error reports
	input wire errStb,
	input wire [nodeBusPkg::ErrCodeWidth-1:0] errCode,
	input wire [nodeBusPkg::SelWidth-1:0] cpsr,
	input wire errRead,
	output logic errValid,
	output logic [nodeBusPkg::SelWidth-1:0] errSel,
	output logic [nodeBusPkg::ErrCodeWidth-1:0] errOut,
	output logic errMsgReq,
	input wire errMsgAck,
	// interrupts
	input wire intReq,
	input wire [nodeBusPkg::IntCodeWidth-1:0] intCode,
	input wire intEna,
	output logic intAck,
	output logic [nodeBusPkg::IntCodeWidth-1:0] intVector,
	input wire coreEmpty,
	input wire coreBkpt,
	output logic coreStop
);
	import nodeBusPkg::*;
	import nodeTimingPkg::*;

	logic nodeClear;
	logic errFull;
	logic errPush;
	returnWord streamWord;
	returnWord netWord;
	returnWord streamHead;
	returnWord netHead;
	returnWord coreWord;
	errorRecord errWord;
	errorRecord errHead;

	returnSource netSrc();
	returnSource streamSrc();
	returnSource localSrc();

	//==========================================================
	// return path
	assign streamWord = '{size: streamSize, tag: streamTag, data: streamData};
	assign netWord = '{size: netSize, tag: netTag, data: netData};

	syncFifo #(.T(returnWord), .Depth(ReturnFifoDepth)) streamFifo
	(
		.EXTCLK(EXTCLK), .rstN(rstN), .clear(nodeClear),
		.push(streamPush), .din(streamWord), .pop(streamSrc.pop),
		.dout(streamHead), .valid(streamSrc.valid), .full(streamFull)
	);

	syncFifo #(.T(returnWord), .Depth(ReturnFifoDepth)) netFifo
	(
		.EXTCLK(EXTCLK), .rstN(rstN), .clear(nodeClear),
		.push(netPush), .din(netWord), .pop(netSrc.pop),
		.dout(netHead), .valid(netSrc.valid), .full(netFull)
	);

	assign {streamSrc.size, streamSrc.tag, streamSrc.data} = streamHead;
	assign {netSrc.size, netSrc.tag, netSrc.data} = netHead;

	// local memory bypasses the buffers
	assign localSrc.valid = localValid;
	assign {localSrc.size, localSrc.tag, localSrc.data} = {localSize, localTag, localData};
	assign localRd = localSrc.pop;

	returnMerge merge
	(
		.EXTCLK(EXTCLK), .rstN(rstN),
		.net(netSrc), .stream(streamSrc), .localIn(localSrc),
		.coreDrdy(coreDrdy), .coreWord(coreWord)
	);

	assign {coreSize, coreTag, coreData} = coreWord;

	//==========================================================
	// error log
	assign errWord = '{sel: cpsr, code: errCode};
	// reports arriving on a full log are lost
	assign errPush = errStb & ~errFull;

	syncFifo #(.T(errorRecord), .Depth(ErrorFifoDepth)) errFifo
	(
		.EXTCLK(EXTCLK), .rstN(rstN), .clear(nodeClear),
		.push(errPush), .din(errWord), .pop(errRead),
		.dout(errHead), .valid(errValid), .full(errFull)
	);

	assign {errSel, errOut} = errHead;

	//==========================================================
	// timing and control
	tickTimer timer
	(
		.EXTCLK(EXTCLK), .rstN(rstN), .clear(nodeClear), .tick(tick)
	);

	nodeControl control
	(
		.EXTCLK(EXTCLK), .rstN(rstN), .softReset(softReset),
		.intReq(intReq), .intCode(intCode), .intEna(intEna),
		.coreEmpty(coreEmpty), .coreBkpt(coreBkpt),
		.errValid(errValid), .errMsgAck(errMsgAck),
		.nodeClear(nodeClear), .intAck(intAck), .intVector(intVector),
		.coreStop(coreStop), .errMsgReq(errMsgReq)
	);

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock
(
	output logic EXTCLK,
	output logic rstN
);

	// 8 ns period
	initial
	begin
		EXTCLK = 1'b0;
		forever #4 EXTCLK = ~EXTCLK;
	end

	// reset held for five rising edges
	initial
	begin
		rstN = 1'b0;
		repeat (5) @(posedge EXTCLK);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/nodeHub_props.sv
`timescale 1ns/1ps
`default_nettype none

module nodeHub_props
(
	input wire EXTCLK,
	input wire rstN,
	input wire streamPush,
	input wire streamFull,
	input wire netPush,
	input wire netFull,
	input wire intReq,
	input wire intAck,
	input wire errMsgReq,
	input wire errMsgAck,
	input wire netPop,
	input wire streamPop,
	input wire localRd
);

	// producers watch full
	noPushWhenFull: assert property (@(posedge EXTCLK) disable iff (!rstN)
		!(streamPush && streamFull) && !(netPush && netFull))
		else $error("push into a full return FIFO");

	intAckNeedsReq: assert property (@(posedge EXTCLK) disable iff (!rstN)
		$rose(intAck) |-> $past(intReq))
		else $error("intAck rose without intReq");

	// request stays up until the host answers
	errReqHeld: assert property (@(posedge EXTCLK) disable iff (!rstN)
		errMsgReq && !errMsgAck |=> errMsgReq)
		else $error("errMsgReq dropped before errMsgAck");

	// one word per cycle onto the core channel
	oneWordPerCycle: assert property (@(posedge EXTCLK) disable iff (!rstN)
		$onehot0({netPop, streamPop, localRd}))
		else $error("more than one source popped in a cycle");

endmodule

bind nodeHub nodeHub_props props
(
	.EXTCLK(EXTCLK), .rstN(rstN),
	.streamPush(streamPush), .streamFull(streamFull),
	.netPush(netPush), .netFull(netFull),
	.intReq(intReq), .intAck(intAck),
	.errMsgReq(errMsgReq), .errMsgAck(errMsgAck),
	.netPop(netSrc.pop), .streamPop(streamSrc.pop), .localRd(localRd)
);

`default_nettype wire

//--- testbench/tbNodeHub.sv
`timescale 1ns/1ps
`default_nettype none

module tbNodeHub;
	import nodeBusPkg::*;
	import nodeTimingPkg::*;

	localparam int ClockPeriod = 8;
	// summed length of the directed tests, in cycles
	localparam int TestCycles = 240;

	logic EXTCLK;
	logic rstN;
	logic softReset;
	logic tick;
	logic streamPush;
	logic [SizeWidth-1:0] streamSize;
	logic [TagWidth-1:0] streamTag;
	logic [DataWidth-1:0] streamData;
	logic streamFull;
	logic netPush;
	logic [SizeWidth-1:0] netSize;
	logic [TagWidth-1:0] netTag;
	logic [DataWidth-1:0] netData;
	logic netFull;
	logic localValid;
	logic [SizeWidth-1:0] localSize;
	logic [TagWidth-1:0] localTag;
	logic [DataWidth-1:0] localData;
	logic localRd;
	logic coreDrdy;
	logic [SizeWidth-1:0] coreSize;
	logic [TagWidth-1:0] coreTag;
	logic [DataWidth-1:0] coreData;
	logic errStb;
	logic [ErrCodeWidth-1:0] errCode;
	logic [SelWidth-1:0] cpsr;
	logic errRead;
	logic errValid;
	logic [SelWidth-1:0] errSel;
	logic [ErrCodeWidth-1:0] errOut;
	logic errMsgReq;
	logic errMsgAck;
	logic intReq;
	logic [IntCodeWidth-1:0] intCode;
	logic intEna;
	logic intAck;
	logic [IntCodeWidth-1:0] intVector;
	logic coreEmpty;
	logic coreBkpt;
	logic coreStop;

	int errors;
	int checks;
	// every word seen on the core channel
	returnWord gotQ[$];

	tbClock clockGen (.EXTCLK(EXTCLK), .rstN(rstN));

	nodeHub dut (.*);

	always @(negedge EXTCLK)
	begin
		if (coreDrdy)
			gotQ.push_back(returnWord'({coreSize, coreTag, coreData}));
	end

	//============================================================
	// checks and helpers
	task automatic checkValue(input logic [127:0] got, input logic [127:0] expected,
		input string what);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got,
				expected);
		end
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	function automatic returnWord randomWord();
		returnWord w;
		w.size = SizeWidth'($urandom);
		w.tag = TagWidth'($urandom);
		w.data = {$urandom, $urandom};
		return w;
	endfunction

	function automatic returnWord coreOut();
		return returnWord'({coreSize, coreTag, coreData});
	endfunction

	//============================================================
	// directed tests
	task automatic resetOutputs();
		checkValue(128'({coreDrdy, localRd, tick, intAck, coreStop, errMsgReq, errValid,
			streamFull, netFull}), 128'(0), "control outputs after reset");
	endtask

	task automatic mergeOrder();
		returnWord w [5];
		foreach (w[i])
			w[i] = randomWord();
		@(posedge EXTCLK);
		netPush <= 1'b1;
		streamPush <= 1'b1;
		{netSize, netTag, netData} <= w[0];
		{streamSize, streamTag, streamData} <= w[2];
		@(posedge EXTCLK);
		{netSize, netTag, netData} <= w[1];
		{streamSize, streamTag, streamData} <= w[3];
		// local offered once the fifo heads are visible
		localValid <= 1'b1;
		{localSize, localTag, localData} <= w[4];
		@(negedge EXTCLK);
		checkValue(128'(coreDrdy), 128'(0), "coreDrdy one cycle after push");
		@(posedge EXTCLK);
		netPush <= 1'b0;
		streamPush <= 1'b0;
		// net words first, then stream words
		for (int i = 0; i < 4; i++)
		begin
			@(negedge EXTCLK);
			checkValue(128'(coreDrdy), 128'(1), "coreDrdy in merge order");
			checkValue(128'(coreOut()), 128'(w[i]), "word in merge order");
		end
		checkValue(128'(localRd), 128'(1), "localRd once the fifos are empty");
		@(posedge EXTCLK);
		localValid <= 1'b0;
		@(negedge EXTCLK);
		checkValue(128'(coreOut()), 128'(w[4]), "local word last");
		@(negedge EXTCLK);
		checkValue(128'(coreDrdy), 128'(0), "core channel idle after merge");
	endtask

	task automatic fillStream();
		returnWord netWords [ReturnFifoDepth];
		returnWord streamWords [ReturnFifoDepth];
		returnWord expected;
		int waited;
		@(posedge EXTCLK);
		gotQ.delete();
		// network traffic keeps the stream fifo from draining
		for (int i = 0; i < ReturnFifoDepth; i++)
		begin
			netWords[i] = randomWord();
			streamWords[i] = randomWord();
			@(posedge EXTCLK);
			netPush <= 1'b1;
			streamPush <= 1'b1;
			{netSize, netTag, netData} <= netWords[i];
			{streamSize, streamTag, streamData} <= streamWords[i];
		end
		@(posedge EXTCLK);
		netPush <= 1'b0;
		streamPush <= 1'b0;
		@(negedge EXTCLK);
		checkValue(128'(streamFull), 128'(1), "streamFull after 16 pushes");
		waited = 0;
		while (gotQ.size() < 2 * ReturnFifoDepth && waited < 4 * ReturnFifoDepth)
		begin
			@(negedge EXTCLK);
			waited++;
		end
		checkValue(128'(gotQ.size()), 128'(2 * ReturnFifoDepth), "words drained");
		for (int i = 0; i < gotQ.size(); i++)
		begin
			expected = (i < ReturnFifoDepth) ? netWords[i] : streamWords[i - ReturnFifoDepth];
			checkValue(128'(gotQ[i]), 128'(expected), "drained word");
		end
		checkValue(128'(streamFull), 128'(0), "streamFull after drain");
	endtask

	task automatic tickSpacing();
		int gap;
		gap = 0;
		while (!tick && gap < 2 * TickScale)
		begin
			@(negedge EXTCLK);
			gap++;
		end
		if (!tick)
			reportFailure("tick never pulsed");
		for (int k = 0; k < 2; k++)
		begin
			gap = 0;
			do
			begin
				@(negedge EXTCLK);
				gap++;
			end
			while (!tick && gap < 2 * TickScale);
			checkValue(128'(gap), 128'(TickScale), "cycles between ticks");
		end
	endtask

	task automatic interruptHandshake();
		logic [IntCodeWidth-1:0] code;
		int waited;
		code = IntCodeWidth'($urandom);
		@(posedge EXTCLK);
		intEna <= 1'b1;
		coreEmpty <= 1'b0;
		coreBkpt <= 1'b0;
		intCode <= code;
		intReq <= 1'b1;
		repeat (3) @(negedge EXTCLK);
		checkValue(128'(coreStop), 128'(1), "coreStop while interrupt pending");
		checkValue(128'(intAck), 128'(0), "intAck while core busy");
		@(posedge EXTCLK);
		coreEmpty <= 1'b1;
		coreBkpt <= 1'b1;
		repeat (3) @(negedge EXTCLK);
		checkValue(128'(intAck), 128'(0), "intAck at breakpoint");
		@(posedge EXTCLK);
		coreBkpt <= 1'b0;
		waited = 0;
		while (!intAck && waited < 10)
		begin
			@(negedge EXTCLK);
			waited++;
		end
		if (!intAck)
			reportFailure("intAck never rose with the core empty");
		checkValue(128'(intVector), 128'(code), "intVector");
		@(posedge EXTCLK);
		intReq <= 1'b0;
		@(negedge EXTCLK);
		checkValue(128'(intAck), 128'(1), "intAck one cycle after intReq falls");
		@(negedge EXTCLK);
		checkValue(128'(intAck), 128'(0), "intAck released");
		// a disabled request must never be acknowledged
		@(posedge EXTCLK);
		intEna <= 1'b0;
		intReq <= 1'b1;
		for (int i = 0; i < 12; i++)
		begin
			@(negedge EXTCLK);
			checkValue(128'(intAck), 128'(0), "intAck with intEna low");
		end
		@(posedge EXTCLK);
		intReq <= 1'b0;
	endtask

	task automatic errorLog();
		errorRecord records [3];
		int waited;
		foreach (records[i])
		begin
			records[i].sel = SelWidth'($urandom);
			records[i].code = ErrCodeWidth'($urandom);
		end
		foreach (records[i])
		begin
			@(posedge EXTCLK);
			errStb <= 1'b1;
			cpsr <= records[i].sel;
			errCode <= records[i].code;
		end
		@(posedge EXTCLK);
		errStb <= 1'b0;
		// one four-phase cycle per record
		foreach (records[i])
		begin
			@(negedge EXTCLK);
			waited = 0;
			while (!errMsgReq && waited < 10)
			begin
				@(negedge EXTCLK);
				waited++;
			end
			if (!errMsgReq)
				reportFailure("errMsgReq missing for a waiting record");
			checkValue(128'(errValid), 128'(1), "errValid with a record waiting");
			checkValue(128'({errSel, errOut}), 128'(records[i]), "error record");
			@(posedge EXTCLK);
			errMsgAck <= 1'b1;
			errRead <= 1'b1;
			@(posedge EXTCLK);
			errRead <= 1'b0;
			@(negedge EXTCLK);
			checkValue(128'(errMsgReq), 128'(0), "errMsgReq after errMsgAck");
			@(posedge EXTCLK);
			errMsgAck <= 1'b0;
		end
		repeat (6) @(negedge EXTCLK);
		checkValue(128'(errValid), 128'(0), "errValid with the log read out");
		checkValue(128'(errMsgReq), 128'(0), "errMsgReq with the log read out");
	endtask

	task automatic softClear();
		for (int i = 0; i < 4; i++)
		begin
			@(posedge EXTCLK);
			netPush <= 1'b1;
			streamPush <= 1'b1;
			{netSize, netTag, netData} <= randomWord();
			{streamSize, streamTag, streamData} <= randomWord();
			errStb <= (i < 2);
			cpsr <= SelWidth'($urandom);
			errCode <= ErrCodeWidth'($urandom);
		end
		@(posedge EXTCLK);
		netPush <= 1'b0;
		streamPush <= 1'b0;
		errStb <= 1'b0;
		softReset <= 1'b1;
		@(posedge EXTCLK);
		softReset <= 1'b0;
		// fifos cleared on the edge after nodeClear
		repeat (2) @(posedge EXTCLK);
		gotQ.delete();
		repeat (8) @(negedge EXTCLK);
		checkValue(128'(gotQ.size()), 128'(0), "words after softReset");
		checkValue(128'(errValid), 128'(0), "errValid after softReset");
		// close the request raised before the clear
		if (errMsgReq)
		begin
			@(posedge EXTCLK);
			errMsgAck <= 1'b1;
			repeat (2) @(posedge EXTCLK);
			errMsgAck <= 1'b0;
		end
		repeat (4) @(negedge EXTCLK);
		checkValue(128'(errMsgReq), 128'(0), "errMsgReq idle after softReset");
	endtask

	//============================================================
	// run
	initial
	begin
		errors = 0;
		checks = 0;
		void'($urandom(32'h9cc4_10c3));
		softReset = 1'b0;
		streamPush = 1'b0;
		{streamSize, streamTag, streamData} = '0;
		netPush = 1'b0;
		{netSize, netTag, netData} = '0;
		localValid = 1'b0;
		{localSize, localTag, localData} = '0;
		errStb = 1'b0;
		errCode = '0;
		cpsr = '0;
		errRead = 1'b0;
		errMsgAck = 1'b0;
		intReq = 1'b0;
		intCode = '0;
		intEna = 1'b0;
		coreEmpty = 1'b0;
		coreBkpt = 1'b0;
		wait (rstN === 1'b1);
		@(negedge EXTCLK);
		resetOutputs();
		mergeOrder();
		fillStream();
		tickSpacing();
		interruptHandshake();
		errorLog();
		softClear();
		repeat (2) @(negedge EXTCLK);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog with a margin of twice the test length
	initial
	begin
		#(2 * TestCycles * ClockPeriod);
		$display("Timeout: tests did not finish within %0d cycles", 2 * TestCycles);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
logic/nodeBusPkg.sv
logic/nodeTimingPkg.sv
logic/returnSource.sv
logic/syncFifo.sv
logic/returnMerge.sv
logic/tickTimer.sv
logic/nodeControl.sv
logic/nodeHub.sv
testbench/tbClock.sv
testbench/nodeHub_props.sv
testbench/tbNodeHub.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tbNodeHub
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
FAIL_MSG = Something failed
PASS_MSG = Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not complete"; exit 1; \
	else echo "test passed"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
